//--- compile.f
src/stacker_pkg.sv
src/display_pkg.sv
src/tick_timer.sv
src/stack_fsm.sv
src/slide_row.sv
src/board_rows.sv
src/matrix_scan.sv
src/stacker_top.sv
tb/tb_clock.sv
tb/stacker_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e

verilator --binary --timing --assert -j 0 --top-module stacker_tb -f compile.f -o stacker_sim
./obj_dir/stacker_sim > sim.log
cat sim.log

if grep -q "TB FAILED" sim.log; then
	exit 1
fi
exit 0

//--- src/board_rows.sv
`timescale 1ns/1ps
`default_nettype none

module board_rows (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       write,
	input  wire stacker_pkg::level_t  level,
	input  wire stacker_pkg::row_t    cur_row,
	input  wire stacker_pkg::status_t status,
	output stacker_pkg::row_t         prev_mask,
	output stacker_pkg::row_t [stacker_pkg::NUM_LEVELS-1:0] board_flat
);

	stacker_pkg::row_t [stacker_pkg::NUM_LEVELS-1:0] rows;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rows <= '0;
		end else if (write) begin
			rows[level] <= cur_row;
		end
	end

	// floor under row 0 is solid
	assign prev_mask = (level == '0) ? stacker_pkg::row_t'('1) : rows[level - 3'd1];

	always_comb begin
		for (int i = 0; i < stacker_pkg::NUM_LEVELS; i++) begin
			board_flat[i] = rows[i];
			if (status == stacker_pkg::ST_PLAYING &&
			    level == stacker_pkg::level_t'(i)) begin
				board_flat[i] = rows[i] | cur_row;  // live segment on top
			end
		end
	end

endmodule

`default_nettype wire

//--- src/display_pkg.sv
`default_nettype none

package display_pkg;

	typedef logic [2:0] col_idx_t;
	typedef logic [7:0] row_sel_t;

	localparam logic [7:0] COL_DARK  = 8'b1111_1111;  // columns are active low
	localparam row_sel_t   ROW_FIRST = 8'b0000_0001;

endpackage

`default_nettype wire

//--- src/matrix_scan.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_scan (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    scan_tick,
	input  wire stacker_pkg::row_t [stacker_pkg::NUM_LEVELS-1:0] board_flat,
	output stacker_pkg::row_t      column,
	output display_pkg::row_sel_t  row_sel
);

	display_pkg::col_idx_t col_pos;
	display_pkg::row_sel_t row_pos;   // one-hot, row being addressed
	stacker_pkg::row_t     row_bits;

	always_comb begin
		row_bits = '0;
		for (int i = 0; i < stacker_pkg::NUM_LEVELS; i++) begin
			if (row_pos[i]) begin
				row_bits = row_bits | board_flat[i];
			end
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			col_pos <= '0;
			row_pos <= display_pkg::ROW_FIRST;
			column  <= display_pkg::COL_DARK;
			row_sel <= display_pkg::ROW_FIRST;
		end else if (scan_tick) begin
			column  <= row_bits[col_pos] ? ~(stacker_pkg::row_t'(1) << col_pos)
			                             : display_pkg::COL_DARK;
			row_sel <= row_pos;
			col_pos <= col_pos + 1'b1;
			if (col_pos == '1)
				row_pos <= {row_pos[6:0], row_pos[7]};  // next row after column 7
		end
	end

	assert property (@(posedge clk) disable iff (!reset) $onehot(row_sel) && $onehot(row_pos));

endmodule

`default_nettype wire

//--- src/slide_row.sv
`timescale 1ns/1ps
`default_nettype none

module slide_row (
	input  wire                       clk,
	input  wire                       reset,
	input  wire stacker_pkg::blocks_t blocks,
	input  wire                       slide_tick,
	input  wire                       load,
	input  wire                       drop,
	input  wire stacker_pkg::row_t    prev_mask,
	output stacker_pkg::row_t         cur_row,
	output logic                      overlap_zero
);

	stacker_pkg::row_t trimmed;
	logic              dir_down;  // 1 while moving toward bit 0
	logic              active;    // set from load until drop

	assign trimmed      = cur_row & prev_mask;
	assign overlap_zero = (trimmed == '0);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			cur_row  <= stacker_pkg::row_t'(1);
			dir_down <= 1'b0;
			active   <= 1'b0;
		end else if (load) begin
			cur_row  <= ~(stacker_pkg::row_t'('1) << (blocks + 3'd1));
			dir_down <= 1'b0;
			active   <= 1'b1;
		end else if (drop) begin
			cur_row <= trimmed;
			active  <= 1'b0;
		end else if (active && slide_tick) begin
			if (!dir_down) begin
				if (cur_row[stacker_pkg::ROW_W-1]) begin
					cur_row  <= cur_row >> 1;  // bounce off bit 7
					dir_down <= 1'b1;
				end else begin
					cur_row <= cur_row << 1;
				end
			end else begin
				if (cur_row[0]) begin
					cur_row  <= cur_row << 1;
					dir_down <= 1'b0;
				end else begin
					cur_row <= cur_row >> 1;
				end
			end
		end
	end

	// a live segment keeps at least one block until it is dropped
	assert property (@(posedge clk) disable iff (!reset) active |-> cur_row != '0);

endmodule

`default_nettype wire

//--- src/stack_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module stack_fsm (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   go,
	input  wire                   overlap_zero,
	output logic                  load,
	output logic                  drop,
	output logic                  write,
	output stacker_pkg::level_t   level,
	output stacker_pkg::status_t  status
);

	stacker_pkg::game_state_t state;
	stacker_pkg::game_state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			stacker_pkg::S_LOAD: begin
				state_nxt = stacker_pkg::S_SLIDE;
			end
			stacker_pkg::S_SLIDE: begin
				if (go)
					state_nxt = stacker_pkg::S_DROP;
			end
			stacker_pkg::S_DROP: begin
				state_nxt = stacker_pkg::S_RELEASE;
			end
			stacker_pkg::S_RELEASE: begin
				if (!go) begin  // wait for the button to come up
					if (status == stacker_pkg::ST_WON)
						state_nxt = stacker_pkg::S_WON;
					else if (status == stacker_pkg::ST_LOST)
						state_nxt = stacker_pkg::S_LOST;
					else
						state_nxt = stacker_pkg::S_LOAD;
				end
			end
			default: begin
				state_nxt = state;  // game over, board frozen
			end
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state  <= stacker_pkg::S_LOAD;
			level  <= '0;
			status <= stacker_pkg::ST_PLAYING;
		end else begin
			state <= state_nxt;
			if (state == stacker_pkg::S_DROP) begin
				if (overlap_zero)
					status <= stacker_pkg::ST_LOST;
				else if (level == stacker_pkg::level_t'(stacker_pkg::NUM_LEVELS - 1))
					status <= stacker_pkg::ST_WON;
				else
					level <= level + 1'b1;
			end
		end
	end

	assign load  = (state == stacker_pkg::S_LOAD);
	assign drop  = (state == stacker_pkg::S_SLIDE) && go;  // trim lands on the next edge
	assign write = (state == stacker_pkg::S_DROP);

	// the level counter must not wrap from the top row back to row 0
	assert property (@(posedge clk) disable iff (!reset)
		level == stacker_pkg::level_t'(stacker_pkg::NUM_LEVELS - 1)
		|=> level == stacker_pkg::level_t'(stacker_pkg::NUM_LEVELS - 1));

endmodule

`default_nettype wire

//--- src/stacker_pkg.sv
`default_nettype none

package stacker_pkg;

	localparam int ROW_W      = 8;
	localparam int NUM_LEVELS = 8;

	typedef logic [ROW_W-1:0] row_t;  // one lit block per bit
	typedef logic [2:0] level_t;
	typedef logic [2:0] rate_t;      // 0 slowest, 7 fastest
	typedef logic [1:0] blocks_t;    // segment width minus one

	typedef enum logic [2:0] {
		S_LOAD,
		S_SLIDE,
		S_DROP,
		S_RELEASE,
		S_WON,
		S_LOST
	} game_state_t;

	typedef enum logic [1:0] {
		ST_PLAYING,
		ST_WON,
		ST_LOST
	} status_t;

endpackage

`default_nettype wire

//--- src/stacker_top.sv
`timescale 1ns/1ps
`default_nettype none

module stacker_top #(
	parameter int TICK_BASE = 50000,
	parameter int SCAN_DIV  = 100
) (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       go,
	input  wire stacker_pkg::rate_t   rate,
	input  wire stacker_pkg::blocks_t blocks,
	output stacker_pkg::row_t         column,
	output display_pkg::row_sel_t     row_sel,
	output stacker_pkg::status_t      status,
	output stacker_pkg::level_t       level
);

	logic slide_tick;
	logic scan_tick;
	logic load;
	logic drop;
	logic write;
	logic overlap_zero;
	stacker_pkg::row_t cur_row;
	stacker_pkg::row_t prev_mask;
	stacker_pkg::row_t [stacker_pkg::NUM_LEVELS-1:0] board_flat;

	tick_timer #(
		.TICK_BASE (TICK_BASE),
		.SCAN_DIV  (SCAN_DIV)
	) u_tick_timer (
		.clk        (clk),
		.reset      (reset),
		.rate       (rate),
		.slide_tick (slide_tick),
		.scan_tick  (scan_tick)
	);

	stack_fsm u_stack_fsm (
		.clk          (clk),
		.reset        (reset),
		.go           (go),
		.overlap_zero (overlap_zero),
		.load         (load),
		.drop         (drop),
		.write        (write),
		.level        (level),
		.status       (status)
	);

	slide_row u_slide_row (
		.clk          (clk),
		.reset        (reset),
		.blocks       (blocks),
		.slide_tick   (slide_tick),
		.load         (load),
		.drop         (drop),
		.prev_mask    (prev_mask),
		.cur_row      (cur_row),
		.overlap_zero (overlap_zero)
	);

	board_rows u_board_rows (
		.clk        (clk),
		.reset      (reset),
		.write      (write),
		.level      (level),
		.cur_row    (cur_row),
		.status     (status),
		.prev_mask  (prev_mask),
		.board_flat (board_flat)
	);

	matrix_scan u_matrix_scan (
		.clk        (clk),
		.reset      (reset),
		.scan_tick  (scan_tick),
		.board_flat (board_flat),
		.column     (column),
		.row_sel    (row_sel)
	);

endmodule

`default_nettype wire

//--- src/tick_timer.sv
`timescale 1ns/1ps
`default_nettype none

module tick_timer #(
	parameter int TICK_BASE = 50000,
	parameter int SCAN_DIV  = 100
) (
	input  wire                     clk,
	input  wire                     reset,
	input  wire stacker_pkg::rate_t rate,
	output logic                    slide_tick,
	output logic                    scan_tick
);

	localparam int SLIDE_W = $clog2(TICK_BASE * 8 + 1);
	localparam int SCAN_W  = $clog2(SCAN_DIV + 1);

	logic [SLIDE_W-1:0] slide_cnt;
	logic [SLIDE_W-1:0] slide_reload;
	logic               slide_run;
	logic [SCAN_W-1:0]  scan_cnt;

	assign slide_reload = SLIDE_W'(TICK_BASE * (8 - int'(rate)) - 1);  // period minus one
	assign slide_tick   = slide_run && (slide_cnt == '0);
	assign scan_tick    = (scan_cnt == '0);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			slide_cnt <= '0;
			slide_run <= 1'b0;
		end else if (!slide_run) begin
			slide_cnt <= slide_reload - 1'b1;  // first cycle out of reset counts
			slide_run <= 1'b1;
		end else if (slide_cnt == '0) begin
			slide_cnt <= slide_reload;         // rate picked up here
		end else begin
			slide_cnt <= slide_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			scan_cnt <= SCAN_W'(SCAN_DIV - 1);
		end else if (scan_cnt == '0) begin
			scan_cnt <= SCAN_W'(SCAN_DIV - 1);
		end else begin
			scan_cnt <= scan_cnt - 1'b1;
		end
	end

	// slide period is at least two cycles for TICK_BASE of two or more
	assert property (@(posedge clk) disable iff (!reset) slide_tick |=> !slide_tick);

	generate
		if (SCAN_DIV > 1) begin : g_scan_pulse
			assert property (@(posedge clk) disable iff (!reset) scan_tick |=> !scan_tick);
		end
	endgenerate

endmodule

`default_nettype wire

//--- tb/stacker_stim.txt
// columns (hex): rate blocks wait_cycles expected_status
// status 0 playing, 1 won, 2 lost, 3 starts a new game
0 3 00 0
1 3 05 0
7 3 1e 0
3 2 0a 0
5 3 00 0
2 1 08 0
6 3 28 0
4 3 03 1
7 3 05 1
0 0 00 3
7 0 00 0
7 0 3c 2
7 1 04 2

//--- tb/stacker_tb.sv
`timescale 1ns/1ps
`default_nettype none

module stacker_tb;

	localparam int TICK_BASE = 4;
	localparam int SCAN_DIV  = 1;

	logic clk;
	logic reset;
	logic restart;
	logic go;
	stacker_pkg::rate_t    rate;
	stacker_pkg::blocks_t  blocks;
	stacker_pkg::row_t     column;
	display_pkg::row_sel_t row_sel;
	stacker_pkg::status_t  status;
	stacker_pkg::level_t   level;

	logic [15:0] stim_mem [0:255];
	int errors = 0;
	int budget = 0;
	int num_lines;

	// reference model state
	stacker_pkg::game_state_t m_state;
	stacker_pkg::status_t     m_status;
	stacker_pkg::level_t      m_level;
	stacker_pkg::row_t        m_seg;
	stacker_pkg::row_t        m_rows [0:7];
	stacker_pkg::row_t        m_col;
	stacker_pkg::row_t        m_rowsel;
	logic                     m_dir_down;
	logic                     m_started;
	logic [2:0]               m_rp;
	logic [2:0]               m_cp;
	int                       m_phase;
	int                       m_period;

	tb_clock u_tb_clock (
		.restart (restart),
		.clk     (clk),
		.reset   (reset)
	);

	stacker_top #(
		.TICK_BASE (TICK_BASE),
		.SCAN_DIV  (SCAN_DIV)
	) u_stacker_top (
		.clk     (clk),
		.reset   (reset),
		.go      (go),
		.rate    (rate),
		.blocks  (blocks),
		.column  (column),
		.row_sel (row_sel),
		.status  (status),
		.level   (level)
	);

	task automatic check_status(input string name, input stacker_pkg::status_t exp,
	                            input stacker_pkg::status_t act);
		if (exp !== act) begin
			errors++;
			$display("[ERROR] %s: expected %s actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic check_level(input string name, input stacker_pkg::level_t exp,
	                           input stacker_pkg::level_t act);
		if (exp !== act) begin
			errors++;
			$display("[ERROR] %s: expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_row(input string name, input stacker_pkg::row_t exp,
	                         input stacker_pkg::row_t act);
		if (exp !== act) begin
			errors++;
			$display("[ERROR] %s: expected %b actual %b", name, exp, act);
		end
	endtask

	function automatic stacker_pkg::row_t row_below();
		return (m_level == 3'd0) ? 8'hff : m_rows[m_level - 3'd1];
	endfunction

	// cycle model, sampled on the same edges as the DUT
	always @(posedge clk or negedge reset) begin : model
		logic              tick;
		stacker_pkg::row_t pre_row;
		if (!reset) begin
			m_state    = stacker_pkg::S_LOAD;
			m_status   = stacker_pkg::ST_PLAYING;
			m_level    = 3'd0;
			m_seg      = 8'h01;
			m_dir_down = 1'b0;
			m_started  = 1'b0;
			m_phase    = 0;
			m_period   = 0;
			m_rp       = 3'd0;
			m_cp       = 3'd0;
			m_col      = 8'hff;
			m_rowsel   = 8'h01;
			for (int i = 0; i < 8; i++)
				m_rows[i] = 8'h00;
		end else begin
			pre_row = m_rows[m_rp];
			if (m_status == stacker_pkg::ST_PLAYING && m_level == m_rp)
				pre_row = pre_row | m_seg;
			m_col    = pre_row[m_cp] ? ~(8'h01 << m_cp) : 8'hff;  // one pixel, active low
			m_rowsel = 8'h01 << m_rp;
			if (m_cp == 3'd7)
				m_rp = m_rp + 3'd1;
			m_cp = m_cp + 3'd1;

			tick = 1'b0;
			if (!m_started) begin
				m_started = 1'b1;
				m_period  = TICK_BASE * (8 - int'(rate));
				m_phase   = 1;
			end else begin
				m_phase++;
				if (m_phase == m_period) begin
					tick     = 1'b1;
					m_period = TICK_BASE * (8 - int'(rate));  // new rate per period
					m_phase  = 0;
				end
			end

			case (m_state)
				stacker_pkg::S_LOAD: begin
					m_seg      = ~(8'hff << (int'(blocks) + 1));
					m_dir_down = 1'b0;
					m_state    = stacker_pkg::S_SLIDE;
				end
				stacker_pkg::S_SLIDE: begin
					if (go) begin
						m_seg   = m_seg & row_below();
						m_state = stacker_pkg::S_DROP;
					end else if (tick) begin
						if (!m_dir_down) begin
							if (m_seg[7]) begin
								m_seg      = m_seg >> 1;
								m_dir_down = 1'b1;
							end else begin
								m_seg = m_seg << 1;
							end
						end else if (m_seg[0]) begin
							m_seg      = m_seg << 1;
							m_dir_down = 1'b0;
						end else begin
							m_seg = m_seg >> 1;
						end
					end
				end
				stacker_pkg::S_DROP: begin
					m_rows[m_level] = m_seg;
					if (m_seg == 8'h00)
						m_status = stacker_pkg::ST_LOST;
					else if (m_level == 3'd7)
						m_status = stacker_pkg::ST_WON;
					else
						m_level = m_level + 3'd1;
					m_state = stacker_pkg::S_RELEASE;
				end
				stacker_pkg::S_RELEASE: begin
					if (!go) begin
						if (m_status == stacker_pkg::ST_WON)
							m_state = stacker_pkg::S_WON;
						else if (m_status == stacker_pkg::ST_LOST)
							m_state = stacker_pkg::S_LOST;
						else
							m_state = stacker_pkg::S_LOAD;
					end
				end
				default: begin
				end
			endcase
		end
	end

	always @(negedge clk) begin
		if (reset) begin
			check_row("scan column", m_col, column);
			check_row("scan row_sel", m_rowsel, row_sel);
			check_level("live level", m_level, level);
			check_status("live status", m_status, status);
		end
	end

	task automatic check_reset_state(input string name);
		check_status(name, stacker_pkg::ST_PLAYING, status);
		check_level(name, 3'd0, level);
		check_row({name, " column"}, 8'hff, column);
		check_row({name, " row_sel"}, 8'h01, row_sel);
	endtask

	task automatic restart_game();
		go      = 1'b0;
		restart = 1'b1;
		wait (reset === 1'b0);
		wait (reset === 1'b1);
		restart = 1'b0;
		check_reset_state("restart");
	endtask

	task automatic run_line(input int idx);
		string                name;
		int                   wait_cyc;
		int                   n;
		logic                 want_hit;
		logic                 done;
		stacker_pkg::status_t exp_st;
		stacker_pkg::level_t  old_level;
		name     = $sformatf("line %0d", idx);
		wait_cyc = int'(stim_mem[4*idx+2]);
		exp_st   = stacker_pkg::status_t'(stim_mem[4*idx+3][1:0]);
		want_hit = (exp_st != stacker_pkg::ST_LOST);
		rate     = stacker_pkg::rate_t'(stim_mem[4*idx]);  // in place before the next load
		blocks   = stacker_pkg::blocks_t'(stim_mem[4*idx+1]);
		n        = 0;
		if (m_status == stacker_pkg::ST_PLAYING) begin
			done = 1'b0;
			while (!done) begin  // press when the model says hit or miss as wanted
				@(posedge clk);
				#1;
				n++;
				if (n >= wait_cyc && m_state == stacker_pkg::S_SLIDE &&
				    (((m_seg & row_below()) != 8'h00) == want_hit))
					done = 1'b1;
			end
			go        = 1'b1;
			old_level = level;
			n         = 0;
			done      = 1'b0;
			while (!done) begin
				@(posedge clk);
				#1;
				n++;
				if (level != old_level || status != stacker_pkg::ST_PLAYING) begin
					done = 1'b1;
				end else if (n > 8) begin
					errors++;
					$display("%s: the press was not answered by a level or status change", name);
					done = 1'b1;
				end
			end
		end else begin
			repeat (wait_cyc) @(posedge clk);
			#1;
			go = 1'b1;
		end
		check_status(name, exp_st, status);
		check_level(name, m_level, level);
		repeat (2 * TICK_BASE * (8 - int'(rate)) + 3) @(posedge clk);  // go held
		#1;
		check_level({name, " held"}, m_level, level);
		go = 1'b0;
		repeat (1 + ($urandom % 4)) @(posedge clk);
		#1;
	endtask

	initial begin
		go      = 1'b0;
		restart = 1'b0;
		rate    = 3'd0;
		blocks  = 2'd0;
		void'($urandom(52));
		for (int i = 0; i < 256; i++)
			stim_mem[i] = 16'hffff;
		$readmemh("tb/stacker_stim.txt", stim_mem);
		num_lines = 0;
		while (num_lines < 64 && stim_mem[4*num_lines] != 16'hffff)
			num_lines++;
		for (int i = 0; i < num_lines; i++)
			budget += int'(stim_mem[4*i+2]) + 200 +
			          20 * TICK_BASE * (8 - int'(stim_mem[4*i][2:0]));
		wait (reset === 1'b1);
		check_reset_state("reset");
		for (int i = 0; i < num_lines; i++) begin
			if (stim_mem[4*i+3] == 16'h0003)
				restart_game();
			else
				run_line(i);
		end
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial begin
		wait (budget > 0);
		repeat (budget) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", budget);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	input  wire  restart,
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;  // 20 ns period
	end

	initial begin
		reset = 1'b0;
		repeat (3) @(posedge clk);
		#1 reset = 1'b1;
		forever begin
			@(posedge restart);  // new game
			reset = 1'b0;
			repeat (3) @(posedge clk);
			#1 reset = 1'b1;
		end
	end

endmodule

`default_nettype wire
